/* alu.sv */
`timescale 1ns/1ns

module alu (
  input  logic                 result_en,
  input  alu_pkg::alu_op_e     operation,
  input  alu_pkg::data_t       a,
  input  alu_pkg::data_t       b,
  output alu_pkg::data_t       out,
  output alu_pkg::alu_status_t status
);
  import alu_pkg::*;

  data_t              out_var;
  data_t              adder_b;
  data_t              adder_out;
  logic               adder_carry;
  logic               adder_overflow;
  logic [shamt_w-1:0] shamt;

  assign shamt   = b[shamt_w-1:0];
  assign adder_b = (operation == sub) ? -b : b;  // a - b as a + (-b)
  assign out     = result_en ? out_var : '0;     // zero instead of a floating bus

  full_adder u_adder (
    .a         (a),
    .b         (adder_b),
    .out       (adder_out),
    .carry_out (adder_carry),
    .overflow  (adder_overflow)
  );

  always_comb begin
    status  = '0;
    out_var = '0;

    unique case (operation)
      pass:   out_var = b;  // unary ops read b
      and_op: out_var = a & b;
      or_op:  out_var = a | b;
      xor_op: out_var = a ^ b;
      not_op: out_var = ~b;
      add, sub: begin
        out_var         = adder_out;
        status.carry    = adder_carry;
        status.overflow = adder_overflow;
      end
      neg:  out_var = -b;

      // carry takes the last bit pushed out of the word
      shl:  {status.carry, out_var} = (data_w + 1)'(a) << shamt;
      shr:  {out_var, status.carry} = {a, 1'b0} >> shamt;
      ashr: {out_var, status.carry} = $signed({a, 1'b0}) >>> shamt;

      // doubled word so the wrapped bits fall into place
      rol:  {status.carry, out_var} = (data_w + 1)'({a, a} >> (data_w - shamt));
      ror:  {out_var, status.carry} = (data_w + 1)'({a, a, 1'b0} >> shamt);

      default: out_var = '0;
    endcase

    status.negative = out_var[data_w-1];
    status.zero     = (out_var == '0);

    // the ports reject unknown op codes, so none should reach an enabled alu
    if (result_en) begin
      a_op_known: assert final (operation inside {[pass:ror]})
        else $error("alu: unknown operation %0h while enabled", operation);
    end
  end

endmodule

/* alu_cluster.f */
alu_pkg.sv
full_adder.sv
alu.sv
alu_regs.sv
cmd_arbiter.sv
axil_cmd_port.sv
alu_cluster.sv
tb_alu_cluster.sv

/* alu_cluster.sv */
`timescale 1ns/1ns

module alu_cluster (
  input  logic               clk,
  input  logic               reset,
  input  logic               s0_awvalid,
  output logic               s0_awready,
  input  alu_pkg::addr_t     s0_awaddr,
  input  logic               s0_wvalid,
  output logic               s0_wready,
  input  alu_pkg::data_t     s0_wdata,
  output logic               s0_bvalid,
  input  logic               s0_bready,
  output alu_pkg::axi_resp_t s0_bresp,
  input  logic               s0_arvalid,
  output logic               s0_arready,
  input  alu_pkg::addr_t     s0_araddr,
  output logic               s0_rvalid,
  input  logic               s0_rready,
  output alu_pkg::data_t     s0_rdata,
  output alu_pkg::axi_resp_t s0_rresp,
  input  logic               s1_awvalid,
  output logic               s1_awready,
  input  alu_pkg::addr_t     s1_awaddr,
  input  logic               s1_wvalid,
  output logic               s1_wready,
  input  alu_pkg::data_t     s1_wdata,
  output logic               s1_bvalid,
  input  logic               s1_bready,
  output alu_pkg::axi_resp_t s1_bresp,
  input  logic               s1_arvalid,
  output logic               s1_arready,
  input  alu_pkg::addr_t     s1_araddr,
  output logic               s1_rvalid,
  input  logic               s1_rready,
  output alu_pkg::data_t     s1_rdata,
  output alu_pkg::axi_resp_t s1_rresp
);
  import alu_pkg::*;

  logic [1:0]    port_req_valid;
  rf_req_t [1:0] port_req;
  logic [1:0]    port_grant;
  rf_rsp_t [1:0] port_rsp;
  logic          rf_req_valid;
  rf_req_t       rf_req;
  rf_rsp_t       rf_rsp;

  axil_cmd_port u_port0 (
    .clk     (clk),        .reset   (reset),
    .awvalid (s0_awvalid), .awready (s0_awready), .awaddr (s0_awaddr),
    .wvalid  (s0_wvalid),  .wready  (s0_wready),  .wdata  (s0_wdata),
    .bvalid  (s0_bvalid),  .bready  (s0_bready),  .bresp  (s0_bresp),
    .arvalid (s0_arvalid), .arready (s0_arready), .araddr (s0_araddr),
    .rvalid  (s0_rvalid),  .rready  (s0_rready),  .rdata  (s0_rdata),
    .rresp   (s0_rresp),
    .req_valid (port_req_valid[0]), .req (port_req[0]),
    .grant     (port_grant[0]),     .rsp (port_rsp[0])
  );

  axil_cmd_port u_port1 (
    .clk     (clk),        .reset   (reset),
    .awvalid (s1_awvalid), .awready (s1_awready), .awaddr (s1_awaddr),
    .wvalid  (s1_wvalid),  .wready  (s1_wready),  .wdata  (s1_wdata),
    .bvalid  (s1_bvalid),  .bready  (s1_bready),  .bresp  (s1_bresp),
    .arvalid (s1_arvalid), .arready (s1_arready), .araddr (s1_araddr),
    .rvalid  (s1_rvalid),  .rready  (s1_rready),  .rdata  (s1_rdata),
    .rresp   (s1_rresp),
    .req_valid (port_req_valid[1]), .req (port_req[1]),
    .grant     (port_grant[1]),     .rsp (port_rsp[1])
  );

  cmd_arbiter u_arbiter (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (port_req_valid),
    .req          (port_req),
    .grant        (port_grant),
    .rf_req_valid (rf_req_valid),
    .rf_req       (rf_req),
    .rf_rsp       (rf_rsp),
    .rsp          (port_rsp)
  );

  alu_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .req_valid (rf_req_valid),
    .req       (rf_req),
    .rsp       (rf_rsp)
  );

endmodule

/* alu_pkg.sv */
package alu_pkg;

  localparam int data_w   = 32;
  localparam int shamt_w  = 5;
  localparam int num_regs = 8;
  localparam int addr_w   = 8;  // address bits decoded by each host port

  typedef logic [data_w-1:0]           data_t;
  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
  typedef logic [addr_w-1:0]           addr_t;
  typedef logic [1:0]                  axi_resp_t;

  typedef enum logic [3:0] {
    pass, and_op, or_op, xor_op, not_op, add, sub,
    neg, shl, shr, ashr, rol, ror
  } alu_op_e;

  typedef struct packed {
    logic carry;
    logic overflow;
    logic negative;
    logic zero;
  } alu_status_t;

  typedef enum logic [1:0] {
    load,
    exec,
    read
  } req_kind_e;

  typedef struct packed {
    req_kind_e kind;
    alu_op_e   op;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    data_t     data;  // value for load
  } rf_req_t;

  typedef struct packed {
    data_t       data;  // read value or alu result
    alu_status_t status;
  } rf_rsp_t;

  // host address map
  localparam addr_t addr_cmd      = 8'h00;
  localparam addr_t addr_status   = 8'h04;
  localparam addr_t addr_reg_base = 8'h20;  // r0..r7 at 0x20..0x3c

  localparam axi_resp_t resp_okay   = 2'b00;
  localparam axi_resp_t resp_slverr = 2'b10;

endpackage

/* alu_regs.sv */
`timescale 1ns/1ns

module alu_regs (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_valid,
  input  alu_pkg::rf_req_t req,
  output alu_pkg::rf_rsp_t rsp
);
  import alu_pkg::*;

  data_t       regs [num_regs];
  data_t       rs1_val;
  data_t       rs2_val;
  data_t       alu_out;
  alu_status_t alu_status;
  logic        result_en;

  // both source reads are combinational
  assign rs1_val   = regs[req.rs1];
  assign rs2_val   = regs[req.rs2];
  assign result_en = req_valid && (req.kind == exec);

  alu u_alu (
    .result_en (result_en),
    .operation (req.op),
    .a         (rs1_val),
    .b         (rs2_val),
    .out       (alu_out),
    .status    (alu_status)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (req_valid) begin
      case (req.kind)
        load:    regs[req.rd] <= req.data;
        exec:    regs[req.rd] <= alu_out;  // result lands at the grant edge
        default: regs[req.rd] <= regs[req.rd];
      endcase
    end
  end

  // same-cycle answer to the granted request
  always_comb begin
    rsp = '0;
    case (req.kind)
      read: rsp.data = rs1_val;
      exec: begin
        rsp.data   = alu_out;
        rsp.status = alu_status;
      end
      default: rsp.data = req.data;  // load echoes the word written
    endcase
  end

endmodule

/* axil_cmd_port.sv */
`timescale 1ns/1ns

module axil_cmd_port (
  input  logic               clk,
  input  logic               reset,
  input  logic               awvalid,
  output logic               awready,
  input  alu_pkg::addr_t     awaddr,
  input  logic               wvalid,
  output logic               wready,
  input  alu_pkg::data_t     wdata,
  output logic               bvalid,
  input  logic               bready,
  output alu_pkg::axi_resp_t bresp,
  input  logic               arvalid,
  output logic               arready,
  input  alu_pkg::addr_t     araddr,
  output logic               rvalid,
  input  logic               rready,
  output alu_pkg::data_t     rdata,
  output alu_pkg::axi_resp_t rresp,
  output logic               req_valid,
  output alu_pkg::rf_req_t   req,
  input  logic               grant,
  input  alu_pkg::rf_rsp_t   rsp
);
  import alu_pkg::*;

  typedef enum logic [1:0] {wr_idle, wr_issue, wr_error, wr_resp} wr_state_e;
  typedef enum logic [1:0] {rd_idle, rd_issue, rd_local, rd_resp} rd_state_e;

  wr_state_e   wr_state;
  rd_state_e   rd_state;
  logic        aw_got;
  logic        w_got;
  logic        aw_done;
  logic        w_done;
  addr_t       awaddr_q;
  data_t       wdata_q;
  addr_t       wr_addr;
  data_t       wr_data;
  logic        op_ok;
  rf_req_t     wr_req;
  rf_req_t     rd_req;
  logic        wr_sel;
  logic        rd_shown;
  alu_status_t last_status;

  function automatic logic is_reg_addr(addr_t addr);
    return (addr[addr_w-1:5] == addr_reg_base[addr_w-1:5]) && (addr[1:0] == 2'b00);
  endfunction

  // aw and w may complete in either order
  assign aw_done = aw_got || (awvalid && awready);
  assign w_done  = w_got || (wvalid && wready);
  assign wr_addr = aw_got ? awaddr_q : awaddr;
  assign wr_data = w_got ? wdata_q : wdata;
  assign op_ok   = wr_data[3:0] <= ror;

  // writes win unless a read already sits on the channel ungranted
  assign wr_sel    = (wr_state == wr_issue) && !rd_shown;
  assign req_valid = (wr_state == wr_issue) || (rd_state == rd_issue);
  assign req       = wr_sel ? wr_req : rd_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_shown <= 1'b0;
    end else begin
      rd_shown <= (rd_state == rd_issue) && !wr_sel && !grant;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state    <= wr_idle;
      awready     <= 1'b0;
      wready      <= 1'b0;
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
      bvalid      <= 1'b0;
      bresp       <= resp_okay;
      last_status <= '0;
    end else begin
      unique case (wr_state)
        wr_idle: begin
          awready <= !aw_done;
          wready  <= !w_done;
          aw_got  <= aw_done;
          w_got   <= w_done;
          if (awvalid && awready) begin
            awaddr_q <= awaddr;
          end
          if (wvalid && wready) begin
            wdata_q <= wdata;
          end
          if (aw_done && w_done) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            if (wr_addr == addr_cmd && op_ok) begin
              wr_req   <= '{kind: exec, op: alu_op_e'(wr_data[3:0]), rd: wr_data[10:8],
                            rs1: wr_data[14:12], rs2: wr_data[18:16], data: '0};
              wr_state <= wr_issue;
            end else if (is_reg_addr(wr_addr)) begin
              wr_req   <= '{kind: load, op: pass, rd: wr_addr[4:2],
                            rs1: '0, rs2: '0, data: wr_data};
              wr_state <= wr_issue;
            end else begin
              wr_state <= wr_error;  // status, bad op or unmapped
            end
          end
        end
        wr_issue: begin
          if (grant && wr_sel) begin
            if (wr_req.kind == exec) begin
              last_status <= rsp.status;  // only this port's own commands
            end
            bresp    <= resp_okay;
            bvalid   <= 1'b1;
            wr_state <= wr_resp;
          end
        end
        wr_error: begin
          bresp    <= resp_slverr;
          bvalid   <= 1'b1;
          wr_state <= wr_resp;
        end
        wr_resp: begin
          if (bready) begin
            bvalid   <= 1'b0;
            wr_state <= wr_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state <= rd_idle;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rresp    <= resp_okay;
    end else begin
      unique case (rd_state)
        rd_idle: begin
          arready <= 1'b1;
          if (arvalid && arready) begin
            arready <= 1'b0;
            if (is_reg_addr(araddr)) begin
              rd_req   <= '{kind: read, op: pass, rd: '0,
                            rs1: araddr[4:2], rs2: '0, data: '0};
              rd_state <= rd_issue;
            end else begin
              // answered here without the arbiter
              rdata    <= (araddr == addr_status) ? data_t'(last_status) : '0;
              rresp    <= (araddr == addr_status) ? resp_okay : resp_slverr;
              rd_state <= rd_local;
            end
          end
        end
        rd_issue: begin
          if (grant && !wr_sel) begin
            rdata    <= rsp.data;
            rresp    <= resp_okay;
            rvalid   <= 1'b1;
            rd_state <= rd_resp;
          end
        end
        rd_local: begin
          rvalid   <= 1'b1;
          rd_state <= rd_resp;
        end
        rd_resp: begin
          if (rready) begin
            rvalid   <= 1'b0;
            rd_state <= rd_idle;
          end
        end
      endcase
    end
  end

endmodule

/* cmd_arbiter.sv */
`timescale 1ns/1ns

module cmd_arbiter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [1:0]             req_valid,
  input  alu_pkg::rf_req_t [1:0] req,
  output logic [1:0]             grant,
  output logic                   rf_req_valid,
  output alu_pkg::rf_req_t       rf_req,
  input  alu_pkg::rf_rsp_t       rf_rsp,
  output alu_pkg::rf_rsp_t [1:0] rsp
);

  logic last_grant;  // port served most recently
  logic sel;

  always_comb begin
    if (req_valid == 2'b11) begin
      sel = ~last_grant;  // both waiting, take turns
    end else begin
      sel = req_valid[1];
    end
  end

  assign grant        = req_valid[sel] ? (2'b01 << sel) : 2'b00;
  assign rf_req_valid = |req_valid;
  assign rf_req       = req[sel];

  // only the granted port sees the answer
  assign rsp[0] = grant[0] ? rf_rsp : '0;
  assign rsp[1] = grant[1] ? rf_rsp : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= 1'b0;
    end else if (rf_req_valid) begin
      last_grant <= sel;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
    else $error("cmd_arbiter: grant %b is not one-hot", grant);

  a_grant_to_req: assert property (@(posedge clk) disable iff (reset)
    (grant & ~req_valid) == 2'b00)
    else $error("cmd_arbiter: grant %b without request %b", grant, req_valid);

endmodule

/* full_adder.sv */
`timescale 1ns/1ns

module full_adder (
  input  alu_pkg::data_t a,
  input  alu_pkg::data_t b,
  output alu_pkg::data_t out,
  output logic           carry_out,
  output logic           overflow
);
  import alu_pkg::*;

  logic [data_w:0] sum;  // one extra bit for the carry

  assign sum       = {1'b0, a} + {1'b0, b};
  assign out       = sum[data_w-1:0];
  assign carry_out = sum[data_w];

  // signed overflow when both operands agree in sign and the result does not
  assign overflow  = (a[data_w-1] == b[data_w-1]) && (out[data_w-1] != a[data_w-1]);

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_alu_cluster \
  -f alu_cluster.f --Mdir obj_dir -o sim_alu_cluster
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_alu_cluster > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
  exit 0
fi
exit 1

/* tb_alu_cluster.sv */
`timescale 1ns/1ns

module tb_alu_cluster;
  import alu_pkg::*;

  localparam int wait_limit = 200;  // cycles any single wait may take

  logic       clk;
  logic       reset;
  logic [1:0] awvalid;
  logic [1:0] awready;
  logic [1:0] wvalid;
  logic [1:0] wready;
  logic [1:0] bvalid;
  logic [1:0] bready;
  logic [1:0] arvalid;
  logic [1:0] arready;
  logic [1:0] rvalid;
  logic [1:0] rready;
  addr_t      awaddr [2];
  addr_t      araddr [2];
  data_t      wdata [2];
  data_t      rdata [2];
  axi_resp_t  bresp [2];
  axi_resp_t  rresp [2];

  data_t model [num_regs];  // expected register contents
  int    fail_count;        // value mismatches, counted by the compare process
  int    proto_errors;      // timeouts, lost or repeated responses
  int    stall_max;         // longest span bready or rready stays low

  string name_q [$];
  data_t exp_q [$];
  data_t act_q [$];

  alu_cluster u_dut (
    .clk        (clk),         .reset      (reset),
    .s0_awvalid (awvalid[0]),  .s0_awready (awready[0]), .s0_awaddr (awaddr[0]),
    .s0_wvalid  (wvalid[0]),   .s0_wready  (wready[0]),  .s0_wdata  (wdata[0]),
    .s0_bvalid  (bvalid[0]),   .s0_bready  (bready[0]),  .s0_bresp  (bresp[0]),
    .s0_arvalid (arvalid[0]),  .s0_arready (arready[0]), .s0_araddr (araddr[0]),
    .s0_rvalid  (rvalid[0]),   .s0_rready  (rready[0]),  .s0_rdata  (rdata[0]),
    .s0_rresp   (rresp[0]),
    .s1_awvalid (awvalid[1]),  .s1_awready (awready[1]), .s1_awaddr (awaddr[1]),
    .s1_wvalid  (wvalid[1]),   .s1_wready  (wready[1]),  .s1_wdata  (wdata[1]),
    .s1_bvalid  (bvalid[1]),   .s1_bready  (bready[1]),  .s1_bresp  (bresp[1]),
    .s1_arvalid (arvalid[1]),  .s1_arready (arready[1]), .s1_araddr (araddr[1]),
    .s1_rvalid  (rvalid[1]),   .s1_rready  (rready[1]),  .s1_rdata  (rdata[1]),
    .s1_rresp   (rresp[1])
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // expected result and flags, straight from the operation rules
  function automatic rf_rsp_t ref_alu(input alu_op_e op, input data_t a, input data_t b);
    rf_rsp_t r;
    data_t   addend;
    logic [data_w:0] sum;
    int      s;
    r = '0;
    s = int'(b[shamt_w-1:0]);
    case (op)
      pass:   r.data = b;
      and_op: r.data = a & b;
      or_op:  r.data = a | b;
      xor_op: r.data = a ^ b;
      not_op: r.data = ~b;
      add, sub: begin
        addend            = (op == sub) ? (~b + 1) : b;  // two's complement for sub
        sum               = {1'b0, a} + {1'b0, addend};
        r.data            = sum[data_w-1:0];
        r.status.carry    = sum[data_w];
        r.status.overflow = (a[31] == addend[31]) && (r.data[31] != a[31]);
      end
      neg: r.data = ~b + 1;
      shl: begin
        r.data = a << s;
        if (s != 0) r.status.carry = a[32 - s];
      end
      shr: begin
        r.data = a >> s;
        if (s != 0) r.status.carry = a[s - 1];
      end
      ashr: begin
        r.data = data_t'($signed(a) >>> s);
        if (s != 0) r.status.carry = a[s - 1];
      end
      rol: begin
        r.data = (s == 0) ? a : ((a << s) | (a >> (32 - s)));
        if (s != 0) r.status.carry = r.data[0];  // last bit to wrap round
      end
      ror: begin
        r.data = (s == 0) ? a : ((a >> s) | (a << (32 - s)));
        if (s != 0) r.status.carry = r.data[31];
      end
      default: r.data = '0;
    endcase
    r.status.negative = r.data[31];
    r.status.zero     = (r.data == '0);
    return r;
  endfunction

  function automatic data_t cmd_word(input alu_op_e op, input reg_idx_t rd,
                                     input reg_idx_t rs1, input reg_idx_t rs2);
    return {13'b0, rs2, 1'b0, rs1, 1'b0, rd, 4'b0, op};
  endfunction

  function automatic addr_t reg_addr(input reg_idx_t r);
    return addr_reg_base + {3'b0, r, 2'b00};
  endfunction

  task automatic queue_check(input string name, input data_t exp, input data_t act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  always @(negedge clk) begin
    string name;
    data_t exp_val;
    data_t act_val;
    while (act_q.size() > 0) begin
      name    = name_q.pop_front();
      exp_val = exp_q.pop_front();
      act_val = act_q.pop_front();
      if (act_val !== exp_val) begin
        fail_count++;
        $display("FAIL %s: expected %h, got %h", name, exp_val, act_val);
      end
    end
  end

  task automatic axi_write(input int p, input addr_t addr, input data_t data,
                           output axi_resp_t resp);
    int   cycles;
    int   stall;
    logic aw_pend;
    logic w_pend;
    logic aw_hs;
    logic w_hs;
    resp = resp_slverr;
    @(negedge clk);
    awaddr[p]  = addr;
    wdata[p]   = data;
    awvalid[p] = 1'b1;
    wvalid[p]  = ($urandom % 2) == 0;  // w sometimes trails aw by a cycle
    aw_pend    = 1'b1;
    w_pend     = 1'b1;
    cycles     = 0;
    while ((aw_pend || w_pend) && cycles < wait_limit) begin
      aw_hs = awvalid[p] && awready[p];
      w_hs  = wvalid[p] && wready[p];
      @(negedge clk);
      cycles++;
      if (aw_hs) begin
        awvalid[p] = 1'b0;
        aw_pend    = 1'b0;
      end
      if (w_hs) begin
        wvalid[p] = 1'b0;
        w_pend    = 1'b0;
      end
      if (w_pend) wvalid[p] = 1'b1;
    end
    if (aw_pend || w_pend) begin
      proto_errors++;
      $display("port %0d: write to %h was never accepted", p, addr);
      awvalid[p] = 1'b0;
      wvalid[p]  = 1'b0;
      return;
    end
    cycles = 0;
    while (!bvalid[p] && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!bvalid[p]) begin
      proto_errors++;
      $display("port %0d: no write response for address %h", p, addr);
      return;
    end
    stall = $urandom_range(stall_max, 0);
    repeat (stall) begin
      @(negedge clk);
      if (!bvalid[p]) begin
        proto_errors++;
        $display("port %0d: write response dropped while bready was low", p);
      end
    end
    resp      = bresp[p];
    bready[p] = 1'b1;
    @(negedge clk);
    bready[p] = 1'b0;
    if (bvalid[p]) begin
      proto_errors++;
      $display("port %0d: write response still valid after its handshake", p);
    end
  endtask

  task automatic axi_read(input int p, input addr_t addr, output data_t data,
                          output axi_resp_t resp);
    int cycles;
    int stall;
    data = '0;
    resp = resp_slverr;
    @(negedge clk);
    araddr[p]  = addr;
    arvalid[p] = 1'b1;
    cycles     = 0;
    while (!arready[p] && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!arready[p]) begin
      proto_errors++;
      $display("port %0d: read of %h was never accepted", p, addr);
      arvalid[p] = 1'b0;
      return;
    end
    @(negedge clk);  // address taken at the edge in between
    arvalid[p] = 1'b0;
    cycles     = 0;
    while (!rvalid[p] && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!rvalid[p]) begin
      proto_errors++;
      $display("port %0d: no read data for address %h", p, addr);
      return;
    end
    stall = $urandom_range(stall_max, 0);
    repeat (stall) begin
      @(negedge clk);
      if (!rvalid[p]) begin
        proto_errors++;
        $display("port %0d: read data dropped while rready was low", p);
      end
    end
    data      = rdata[p];
    resp      = rresp[p];
    rready[p] = 1'b1;
    @(negedge clk);
    rready[p] = 1'b0;
    if (rvalid[p]) begin
      proto_errors++;
      $display("port %0d: read data still valid after its handshake", p);
    end
  endtask

  task automatic load_reg(input int p, input reg_idx_t r, input data_t value);
    axi_resp_t resp;
    axi_write(p, reg_addr(r), value, resp);
    queue_check($sformatf("port%0d bresp load r%0d", p, r), data_t'(resp_okay), data_t'(resp));
    model[r] = value;
  endtask

  task automatic check_all_regs(input int p);
    data_t     got;
    axi_resp_t resp;
    int        r;
    for (r = 0; r < num_regs; r++) begin
      axi_read(p, reg_addr(reg_idx_t'(r)), got, resp);
      queue_check($sformatf("port%0d rdata r%0d", p, r), model[r], got);
      queue_check($sformatf("port%0d rresp r%0d", p, r), data_t'(resp_okay), data_t'(resp));
    end
  endtask

  // load both sources, issue the command, read back rd and this port's status
  task automatic run_op(input int p, input alu_op_e op, input reg_idx_t rd,
                        input reg_idx_t rs1, input reg_idx_t rs2,
                        input data_t a, input data_t b);
    rf_rsp_t   exp;
    data_t     got;
    axi_resp_t resp;
    load_reg(p, rs1, a);
    load_reg(p, rs2, b);
    exp = ref_alu(op, model[rs1], model[rs2]);
    axi_write(p, addr_cmd, cmd_word(op, rd, rs1, rs2), resp);
    queue_check($sformatf("port%0d bresp %s", p, op.name()), data_t'(resp_okay), data_t'(resp));
    model[rd] = exp.data;
    axi_read(p, reg_addr(rd), got, resp);
    queue_check($sformatf("port%0d result %s r%0d", p, op.name(), rd), exp.data, got);
    axi_read(p, addr_status, got, resp);
    queue_check($sformatf("port%0d status %s", p, op.name()), data_t'(exp.status), got);
    queue_check($sformatf("port%0d rresp status %s", p, op.name()), data_t'(resp_okay),
                data_t'(resp));
  endtask

  // random commands confined to registers base to base+3
  task automatic random_ops(input int p, input int base, input int count);
    int n;
    for (n = 0; n < count; n++) begin
      run_op(p, alu_op_e'($urandom_range(12, 0)),
             reg_idx_t'(base + ($urandom % 4)), reg_idx_t'(base + ($urandom % 4)),
             reg_idx_t'(base + ($urandom % 4)), $urandom, $urandom);
    end
  endtask

  initial begin
    axi_resp_t resp;
    data_t     got;
    data_t     b;
    int        op;
    int        k;
    int        r;
    void'($urandom(32'heb9d_4c8e));
    fail_count   = 0;
    proto_errors = 0;
    stall_max    = 2;
    reset        = 1'b1;
    awvalid      = '0;
    wvalid       = '0;
    bready       = '0;
    arvalid      = '0;
    rready       = '0;
    for (r = 0; r < 2; r++) begin
      awaddr[r] = '0;
      araddr[r] = '0;
      wdata[r]  = '0;
    end
    for (r = 0; r < num_regs; r++) begin
      model[r] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // load every register, read all back through both ports
    for (r = 0; r < num_regs; r++) begin
      load_reg(r % 2, reg_idx_t'(r), $urandom);
    end
    check_all_regs(0);
    check_all_regs(1);

    // every operation, with shift amounts 0 and 31 among the operands
    for (op = 0; op <= 12; op++) begin
      for (k = 0; k < 4; k++) begin
        b = $urandom;
        if (k == 0) b[4:0] = 5'd0;
        if (k == 1) b[4:0] = 5'd31;
        run_op($urandom % 2, alu_op_e'(op), reg_idx_t'($urandom), reg_idx_t'($urandom),
               reg_idx_t'($urandom), $urandom, b);
      end
    end

    // flag corner cases
    run_op(0, add, 3'd2, 3'd0, 3'd1, 32'h7fff_ffff, 32'h0000_0001);
    run_op(1, sub, 3'd2, 3'd0, 3'd1, 32'h0000_0000, 32'h0000_0001);
    run_op(0, add, 3'd5, 3'd3, 3'd4, 32'hffff_ffff, 32'h0000_0001);
    run_op(1, sub, 3'd5, 3'd3, 3'd4, 32'h8000_0000, 32'h0000_0001);
    run_op(0, sub, 3'd7, 3'd6, 3'd6, 32'h1234_5678, 32'h1234_5678);
    run_op(1, neg, 3'd7, 3'd6, 3'd0, 32'h0000_0000, 32'h8000_0000);
    run_op(0, add, 3'd1, 3'd2, 3'd3, 32'h8000_0000, 32'h8000_0000);

    // both ports at once, no stalls so they contend for the arbiter
    stall_max = 0;
    fork
      random_ops(0, 0, 12);
      random_ops(1, 4, 12);
    join

    // error responses leave the registers alone
    stall_max = 2;
    axi_write(0, 8'h10, $urandom, resp);
    queue_check("port0 bresp unmapped", data_t'(resp_slverr), data_t'(resp));
    axi_write(1, addr_status, $urandom, resp);
    queue_check("port1 bresp status write", data_t'(resp_slverr), data_t'(resp));
    axi_write(0, 8'h22, $urandom, resp);
    queue_check("port0 bresp misaligned", data_t'(resp_slverr), data_t'(resp));
    axi_write(1, addr_cmd, 32'h0000_010d, resp);
    queue_check("port1 bresp bad op", data_t'(resp_slverr), data_t'(resp));
    axi_read(0, 8'h10, got, resp);
    queue_check("port0 rresp unmapped", data_t'(resp_slverr), data_t'(resp));
    axi_read(1, 8'h40, got, resp);
    queue_check("port1 rresp unmapped", data_t'(resp_slverr), data_t'(resp));
    check_all_regs(0);
    check_all_regs(1);

    // long back-pressure spans on both ports
    stall_max = 8;
    fork
      random_ops(0, 0, 8);
      random_ops(1, 4, 8);
    join
    check_all_regs(1);

    repeat (2) @(negedge clk);  // compare process drains its queue
    $display("errors: %0d value mismatches, %0d protocol errors", fail_count, proto_errors);
    if (fail_count == 0 && proto_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
